/* src/xt_io_map_pkg.sv */
// I/O and memory map constants for the XT peripheral glue
// Bus widths, port bases and EMS frame segments

package xt_io_map_pkg;

    // Bus widths
    localparam int ADDR_W         = 20;
    localparam int DATA_W         = 8;
    localparam int IO_DECODE_BITS = 10;

    // Legacy chip selects in the first 256 ports, 32 ports each
    localparam int LEGACY_CS_COUNT = 5;

    // EMS page registers at 260h..263h
    localparam logic [IO_DECODE_BITS-1:0] EMS_PORT_BASE = 10'h260;

    // Parallel data port, decoded on an 8-port boundary
    localparam logic [IO_DECODE_BITS-1:0] LPT_PORT_BASE = 10'h378;
    localparam int                        LPT_SPAN_W    = 3;

    // EMS windows of 16 KB each
    localparam int EMS_BANKS  = 4;
    localparam int EMS_BANK_W = $clog2(EMS_BANKS);
    localparam int EMS_PAGE_W = 7;

    // Top address bits of the EMS frame choices
    localparam int                   EMS_SEG_W = 4;
    localparam logic [EMS_SEG_W-1:0] EMS_SEG_A = 4'hA;
    localparam logic [EMS_SEG_W-1:0] EMS_SEG_C = 4'hC;
    localparam logic [EMS_SEG_W-1:0] EMS_SEG_D = 4'hD;

endpackage

/* src/xt_ctrl_pkg.sv */
// Control definitions for the XT peripheral glue
// Read source selector and EMS command values

package xt_ctrl_pkg;

    import xt_io_map_pkg::*;

    // Device driving the chipset read data
    typedef enum logic [1:0] {
        RD_NONE = 2'd0,
        RD_EMS  = 2'd1,
        RD_LPT  = 2'd2
    } read_src_e;

    // EMS register write values
    localparam logic [DATA_W-1:0]     EMS_CMD_UNMAP     = 8'hFF;
    localparam logic [DATA_W-1:0]     EMS_MAP_LIMIT     = 8'h80;
    localparam logic [EMS_PAGE_W-1:0] EMS_UNMAPPED_PAGE = 7'h7F;

    // Read value of a disabled EMS bank
    localparam logic [DATA_W-1:0] IDLE_READ = 8'hFF;

    // Parallel port latch after reset
    localparam logic [DATA_W-1:0] LPT_RESET_DATA = 8'hFF;

endpackage

/* src/io_decoder.sv */
// I/O port decoder
// Legacy chip selects, EMS and LPT write strobes, read source select

module io_decoder import xt_io_map_pkg::*, xt_ctrl_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic [ADDR_W-1:0] address_i,
    input  logic              aen_n_i,
    input  logic              io_read_n_i,
    input  logic              io_write_n_i,
    input  logic              ems_enable_i,
    output logic              dma_cs_n_o,
    output logic              pic_cs_n_o,
    output logic              pit_cs_n_o,
    output logic              ppi_cs_n_o,
    output logic              dma_page_cs_n_o,
    output logic              ems_wr_o,
    output logic              lpt_wr_o,
    output read_src_e         read_src_o
);

    logic [IO_DECODE_BITS-1:0]  port;
    logic                       legacy_space;
    logic [LEGACY_CS_COUNT-1:0] cs_n;
    logic                       ems_sel;
    logic                       lpt_sel;

    assign port = address_i[IO_DECODE_BITS-1:0];

    // First 256 ports, CPU owns the bus
    assign legacy_space = ~aen_n_i && (port[IO_DECODE_BITS-1:8] == '0);

    // 32-port groups from bits 7..5, only the first five are used
    always_comb begin
        cs_n = '1;
        if (legacy_space && (port[7:5] < LEGACY_CS_COUNT)) begin
            cs_n[port[7:5]] = 1'b0;
        end
    end

    assign dma_cs_n_o      = cs_n[0];
    assign pic_cs_n_o      = cs_n[1];
    assign pit_cs_n_o      = cs_n[2];
    assign ppi_cs_n_o      = cs_n[3];
    assign dma_page_cs_n_o = cs_n[4];

    // Board-level ports
    assign ems_sel = ~aen_n_i && ems_enable_i &&
        (port[IO_DECODE_BITS-1:EMS_BANK_W] == EMS_PORT_BASE[IO_DECODE_BITS-1:EMS_BANK_W]);
    assign lpt_sel = ~aen_n_i &&
        (port[IO_DECODE_BITS-1:LPT_SPAN_W] == LPT_PORT_BASE[IO_DECODE_BITS-1:LPT_SPAN_W]);

    // Level strobes, held for the whole write cycle
    assign ems_wr_o = ems_sel && ~io_write_n_i;
    assign lpt_wr_o = lpt_sel && ~io_write_n_i;

    always_comb begin
        read_src_o = RD_NONE;
        if (~io_read_n_i) begin
            if (ems_sel) begin
                read_src_o = RD_EMS;
            end else if (lpt_sel) begin
                read_src_o = RD_LPT;
            end
        end
    end

    // External chips must never see two selects at once
    a_legacy_cs_onehot: assert property (
        @(posedge clock) disable iff (reset) $onehot0(~cs_n)
    ) else $error("more than one legacy chip select active: %b", cs_n);

endmodule

/* src/ems_mapper.sv */
// EMS page mapping registers
// Write rules, 16 KB window hit detection and register readback

module ems_mapper import xt_io_map_pkg::*, xt_ctrl_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic [ADDR_W-1:0]     address_i,
    input  logic [DATA_W-1:0]     data_i,
    input  logic                  ems_wr_i,
    input  logic [1:0]            ems_base_sel_i,
    output logic [EMS_BANKS-1:0]  ems_bank_hit_o,
    output logic [EMS_PAGE_W-1:0] ems_page_o,
    output logic [DATA_W-1:0]     ems_rd_data_o
);

    localparam int WIN_W = EMS_SEG_W + EMS_BANK_W;

    logic [EMS_PAGE_W-1:0] page_q [EMS_BANKS];
    logic [EMS_BANKS-1:0]  enable_q;
    logic [EMS_BANK_W-1:0] bank_sel;
    logic [EMS_SEG_W-1:0]  frame;
    logic [WIN_W-1:0]      window_addr;

    // Register index from the low port bits
    assign bank_sel = address_i[EMS_BANK_W-1:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < EMS_BANKS; i++) begin
                page_q[i] <= '0;
            end
            enable_q <= '0;
        end else if (ems_wr_i) begin
            if (data_i == EMS_CMD_UNMAP) begin
                page_q[bank_sel]   <= EMS_UNMAPPED_PAGE;
                enable_q[bank_sel] <= 1'b0;
            end else if (data_i < EMS_MAP_LIMIT) begin
                page_q[bank_sel]   <= data_i[EMS_PAGE_W-1:0];
                enable_q[bank_sel] <= 1'b1;
            end
            // 80h..FEh are ignored
        end
    end

    // Frame segment A000h, C000h or D000h
    always_comb begin
        case (ems_base_sel_i)
            2'd0:    frame = EMS_SEG_A;
            2'd1:    frame = EMS_SEG_C;
            default: frame = EMS_SEG_D;
        endcase
    end

    assign window_addr = address_i[ADDR_W-1 -: WIN_W];

    for (genvar b = 0; b < EMS_BANKS; b++) begin : g_hit
        assign ems_bank_hit_o[b] = enable_q[b] &&
            (window_addr == {frame, EMS_BANK_W'(b)});
    end

    // Page of the hitting bank, zero on a miss
    always_comb begin
        ems_page_o = '0;
        for (int i = 0; i < EMS_BANKS; i++) begin
            if (ems_bank_hit_o[i]) begin
                ems_page_o = page_q[i];
            end
        end
    end

    assign ems_rd_data_o = enable_q[bank_sel] ?
        {{(DATA_W - EMS_PAGE_W){1'b0}}, page_q[bank_sel]} : IDLE_READ;

    a_bank_hit_onehot: assert property (
        @(posedge clock) disable iff (reset) $onehot0(ems_bank_hit_o)
    ) else $error("several EMS banks hit: %b", ems_bank_hit_o);

endmodule

/* src/kbd_sync.sv */
// Keyboard hand-off into the system clock domain
// Scancode and IRQ synchronizer, reset request pulse, PS/2 clock inhibit

module kbd_sync import xt_io_map_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic [DATA_W-1:0] kbd_keycode_i,
    input  logic              kbd_irq_i,
    input  logic              ps2_reset_n_i,
    output logic [DATA_W-1:0] kbd_port_a_o,
    output logic              kbd_irq_o,
    output logic              kbd_reset_req_o,
    output logic              ps2_clock_o
);

    logic [DATA_W-1:0] keycode_q;
    logic              irq_q;
    logic              reset_n_q;
    logic              reset_n_d;
    logic              reset_rise;

    // Two register stages for scancode and IRQ
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            keycode_q    <= '0;
            kbd_port_a_o <= '0;
            irq_q        <= 1'b0;
            kbd_irq_o    <= 1'b0;
        end else begin
            keycode_q    <= kbd_keycode_i;
            kbd_port_a_o <= keycode_q;
            irq_q        <= kbd_irq_i;
            kbd_irq_o    <= irq_q;
        end
    end

    // Keyboard reset line starts out released
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            reset_n_q       <= 1'b1;
            reset_n_d       <= 1'b1;
            kbd_reset_req_o <= 1'b0;
        end else begin
            reset_n_q       <= ps2_reset_n_i;
            reset_n_d       <= reset_n_q;
            kbd_reset_req_o <= reset_rise;
        end
    end

    assign reset_rise = reset_n_q & ~reset_n_d;

    // Hold the keyboard off while a code is pending or reset is held
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ps2_clock_o <= 1'b1;
        end else begin
            ps2_clock_o <= ~(kbd_irq_i | ~ps2_reset_n_i);
        end
    end

    a_reset_req_pulse: assert property (
        @(posedge clock) disable iff (reset) kbd_reset_req_o |=> !kbd_reset_req_o
    ) else $error("keyboard reset request held longer than one cycle");

endmodule

/* src/bus_readback.sv */
// Parallel port data latch
// Chipset read data multiplexer

module bus_readback import xt_io_map_pkg::*, xt_ctrl_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic [DATA_W-1:0] data_i,
    input  logic              lpt_wr_i,
    input  read_src_e         read_src_i,
    input  logic [DATA_W-1:0] ems_rd_data_i,
    output logic [DATA_W-1:0] data_o,
    output logic              data_valid_o,
    output logic [DATA_W-1:0] lpt_data_o
);

    // LPT data register, loaded on every edge of the write strobe
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lpt_data_o <= LPT_RESET_DATA;
        end else if (lpt_wr_i) begin
            lpt_data_o <= data_i;
        end
    end

    // Read data, same cycle as the strobe
    always_comb begin
        case (read_src_i)
            RD_EMS: begin
                data_o       = ems_rd_data_i;
                data_valid_o = 1'b1;
            end
            RD_LPT: begin
                data_o       = lpt_data_o;
                data_valid_o = 1'b1;
            end
            default: begin
                data_o       = '0;
                data_valid_o = 1'b0;
            end
        endcase
    end

endmodule

/* src/xt_peripherals.sv */
// XT peripheral board I/O and memory glue
// Port decoder, EMS mapper, keyboard hand-off and chipset readback

module xt_peripherals import xt_io_map_pkg::*, xt_ctrl_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    // System bus
    input  logic [ADDR_W-1:0]     address_i,
    input  logic                  aen_n_i,
    input  logic                  io_read_n_i,
    input  logic                  io_write_n_i,
    input  logic [DATA_W-1:0]     data_i,
    output logic [DATA_W-1:0]     data_o,
    output logic                  data_valid_o,
    // Legacy chip selects
    output logic                  dma_cs_n_o,
    output logic                  pic_cs_n_o,
    output logic                  pit_cs_n_o,
    output logic                  ppi_cs_n_o,
    output logic                  dma_page_cs_n_o,
    // EMS
    input  logic                  ems_enable_i,
    input  logic [1:0]            ems_base_sel_i,
    output logic [EMS_BANKS-1:0]  ems_bank_hit_o,
    output logic [EMS_PAGE_W-1:0] ems_page_o,
    // Parallel port
    output logic [DATA_W-1:0]     lpt_data_o,
    // Keyboard
    input  logic [DATA_W-1:0]     kbd_keycode_i,
    input  logic                  kbd_irq_i,
    input  logic                  ps2_reset_n_i,
    output logic [DATA_W-1:0]     kbd_port_a_o,
    output logic                  kbd_irq_o,
    output logic                  kbd_reset_req_o,
    output logic                  ps2_clock_o
);

    logic              ems_wr;
    logic              lpt_wr;
    read_src_e         read_src;
    logic [DATA_W-1:0] ems_rd_data;

    io_decoder i_io_decoder (
        .clock           (clock),
        .reset           (reset),
        .address_i       (address_i),
        .aen_n_i         (aen_n_i),
        .io_read_n_i     (io_read_n_i),
        .io_write_n_i    (io_write_n_i),
        .ems_enable_i    (ems_enable_i),
        .dma_cs_n_o      (dma_cs_n_o),
        .pic_cs_n_o      (pic_cs_n_o),
        .pit_cs_n_o      (pit_cs_n_o),
        .ppi_cs_n_o      (ppi_cs_n_o),
        .dma_page_cs_n_o (dma_page_cs_n_o),
        .ems_wr_o        (ems_wr),
        .lpt_wr_o        (lpt_wr),
        .read_src_o      (read_src)
    );

    ems_mapper i_ems_mapper (
        .clock          (clock),
        .reset          (reset),
        .address_i      (address_i),
        .data_i         (data_i),
        .ems_wr_i       (ems_wr),
        .ems_base_sel_i (ems_base_sel_i),
        .ems_bank_hit_o (ems_bank_hit_o),
        .ems_page_o     (ems_page_o),
        .ems_rd_data_o  (ems_rd_data)
    );

    kbd_sync i_kbd_sync (
        .clock           (clock),
        .reset           (reset),
        .kbd_keycode_i   (kbd_keycode_i),
        .kbd_irq_i       (kbd_irq_i),
        .ps2_reset_n_i   (ps2_reset_n_i),
        .kbd_port_a_o    (kbd_port_a_o),
        .kbd_irq_o       (kbd_irq_o),
        .kbd_reset_req_o (kbd_reset_req_o),
        .ps2_clock_o     (ps2_clock_o)
    );

    bus_readback i_bus_readback (
        .clock         (clock),
        .reset         (reset),
        .data_i        (data_i),
        .lpt_wr_i      (lpt_wr),
        .read_src_i    (read_src),
        .ems_rd_data_i (ems_rd_data),
        .data_o        (data_o),
        .data_valid_o  (data_valid_o),
        .lpt_data_o    (lpt_data_o)
    );

endmodule

/* verif/tb_xt_peripherals.sv */
// Testbench for the XT peripheral glue
// Runs the operations of the pattern file against the DUT

module tb_xt_peripherals import xt_io_map_pkg::*; ;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_OPS = 64;

    logic                  clock;
    logic                  reset;
    logic [ADDR_W-1:0]     address_i;
    logic                  aen_n_i;
    logic                  io_read_n_i;
    logic                  io_write_n_i;
    logic [DATA_W-1:0]     data_i;
    logic [DATA_W-1:0]     data_o;
    logic                  data_valid_o;
    logic                  dma_cs_n_o;
    logic                  pic_cs_n_o;
    logic                  pit_cs_n_o;
    logic                  ppi_cs_n_o;
    logic                  dma_page_cs_n_o;
    logic                  ems_enable_i;
    logic [1:0]            ems_base_sel_i;
    logic [EMS_BANKS-1:0]  ems_bank_hit_o;
    logic [EMS_PAGE_W-1:0] ems_page_o;
    logic [DATA_W-1:0]     lpt_data_o;
    logic [DATA_W-1:0]     kbd_keycode_i;
    logic                  kbd_irq_i;
    logic                  ps2_reset_n_i;
    logic [DATA_W-1:0]     kbd_port_a_o;
    logic                  kbd_irq_o;
    logic                  kbd_reset_req_o;
    logic                  ps2_clock_o;

    // Four words per operation in op, address, data, expected order
    logic [19:0] patterns [0:4*MAX_OPS-1];
    integer      seed = 32'h00b6e2ac;
    int          op_count;
    int          cycle_limit;
    int          cycle_count;
    int          checks;
    int          errors;

    xt_peripherals i_xt_peripherals (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("Timeout: pattern run did not finish within %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

    task automatic compare_value(input string name, input logic [15:0] actual,
                                 input logic [15:0] expected);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    // Parallel data port spans 378h..37Fh
    function automatic logic is_lpt_port(input logic [19:0] addr);
        return (addr[9:0] >= 10'h378) && (addr[9:0] <= 10'h37F);
    endfunction

    task automatic bus_write(input logic [19:0] addr, input logic [7:0] value);
        @(posedge clock);
        address_i    <= addr;
        data_i       <= value;
        aen_n_i      <= 1'b0;
        io_write_n_i <= 1'b0;
        // Strobe is seen by the register on this edge
        @(posedge clock);
        io_write_n_i <= 1'b1;
    endtask

    task automatic bus_read_check(input logic [19:0] addr, input logic [8:0] expected);
        @(posedge clock);
        address_i   <= addr;
        aen_n_i     <= 1'b0;
        io_read_n_i <= 1'b0;
        @(negedge clock);
        compare_value("data_valid_o", data_valid_o, expected[8]);
        compare_value("data_o", data_o, expected[7:0]);
        if (is_lpt_port(addr)) begin
            compare_value("lpt_data_o", lpt_data_o, expected[7:0]);
        end
        @(posedge clock);
        io_read_n_i <= 1'b1;
    endtask

    task automatic keyboard_stream(input int count);
        logic [7:0] codes [$];
        logic       irqs [$];
        logic [7:0] code;
        logic       irq;
        for (int i = 0; i < count + 2; i++) begin
            code = 8'($random(seed));
            irq  = 1'($random(seed));
            codes.push_back(code);
            irqs.push_back(irq);
            @(posedge clock);
            kbd_keycode_i <= code;
            kbd_irq_i     <= irq;
            @(negedge clock);
            // Inhibit lags one edge and scancode and IRQ lag two
            if (i >= 1) begin
                compare_value("ps2_clock_o", ps2_clock_o, !irqs[i-1]);
            end
            if (i >= 2) begin
                compare_value("kbd_port_a_o", kbd_port_a_o, codes[i-2]);
                compare_value("kbd_irq_o", kbd_irq_o, irqs[i-2]);
            end
        end
    endtask

    task automatic ps2_reset_pulse(input int hold);
        @(posedge clock);
        kbd_irq_i     <= 1'b0;
        ps2_reset_n_i <= 1'b0;
        repeat (hold) @(posedge clock);
        @(negedge clock);
        compare_value("ps2_clock_o", ps2_clock_o, 1'b0);
        @(posedge clock);
        ps2_reset_n_i <= 1'b1;
        // Request only on the second edge after the rise
        for (int j = 1; j <= 6; j++) begin
            @(posedge clock);
            @(negedge clock);
            compare_value("kbd_reset_req_o", kbd_reset_req_o, j == 2);
            if (j == 1) begin
                compare_value("ps2_clock_o", ps2_clock_o, 1'b1);
            end
        end
    endtask

    initial begin
        logic [19:0] op;
        logic [19:0] addr;
        logic [19:0] value;
        logic [19:0] expected;
        int          errors_before;
        reset          = 1'b1;
        address_i      = '0;
        aen_n_i        = 1'b1;
        io_read_n_i    = 1'b1;
        io_write_n_i   = 1'b1;
        data_i         = '0;
        ems_enable_i   = 1'b1;
        ems_base_sel_i = 2'd0;
        kbd_keycode_i  = '0;
        kbd_irq_i      = 1'b0;
        ps2_reset_n_i  = 1'b1;
        checks         = 0;
        errors         = 0;
        cycle_count    = 0;
        op_count       = 0;
        $readmemh("verif/xt_patterns.txt", patterns);
        while (op_count < MAX_OPS && patterns[4*op_count] !== 20'hF &&
               !$isunknown(patterns[4*op_count])) begin
            op_count++;
        end
        cycle_limit = op_count * 8 + 50;
        if (op_count == 0) begin
            $display("Pattern file holds no operations");
            errors++;
        end
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        for (int t = 0; t < op_count; t++) begin
            op            = patterns[4*t];
            addr          = patterns[4*t+1];
            value         = patterns[4*t+2];
            expected      = patterns[4*t+3];
            errors_before = errors;
            case (op)
                20'h1: bus_write(addr, value[7:0]);
                20'h2: bus_read_check(addr, expected[8:0]);
                20'h3: begin
                    @(posedge clock);
                    address_i <= addr;
                    aen_n_i   <= value[0];
                    @(negedge clock);
                    compare_value("cs_n", {dma_page_cs_n_o, ppi_cs_n_o, pit_cs_n_o,
                                           pic_cs_n_o, dma_cs_n_o}, expected[4:0]);
                end
                20'h4: begin
                    @(posedge clock);
                    address_i      <= addr;
                    ems_base_sel_i <= value[1:0];
                    @(negedge clock);
                    compare_value("ems_bank_hit_o", ems_bank_hit_o, expected[11:8]);
                    compare_value("ems_page_o", ems_page_o, expected[7:0]);
                end
                20'h5: begin
                    @(posedge clock);
                    ems_enable_i <= value[0];
                end
                20'h6: keyboard_stream(value);
                20'h7: ps2_reset_pulse(value);
                default: begin
                    $display("Unknown opcode %h in pattern %0d", op, t);
                    errors++;
                end
            endcase
            $display("test %0d op %h addr %h data %h: %s", t, op[3:0], addr, value[7:0],
                     (errors == errors_before) ? "ok" : "FAILED");
        end
        $display("tests %0d, checks %0d, errors %0d", op_count, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/xt_io_map_pkg.sv
src/xt_ctrl_pkg.sv
src/io_decoder.sv
src/ems_mapper.sv
src/kbd_sync.sv
src/bus_readback.sv
src/xt_peripherals.sv
verif/tb_xt_peripherals.sv

/* verif/xt_patterns.txt */
// op addr data expect. 1 write, 2 read {valid,data}, 3 cs aen_n -> cs_n[4:0]
// 4 window base_sel -> {hit,page}, 5 EMS enable, 6 keycodes, 7 PS/2 reset, F end
3 00000 0 1E
3 00000 1 1F
3 00020 0 1D
3 00040 0 1B
3 00060 0 17
3 00080 0 0F
3 00300 0 1F
2 00262 00 1FF
1 00260 05 000
2 00260 00 105
1 00260 FF 000
2 00260 00 1FF
1 00261 22 000
2 00261 00 122
1 00261 90 000
2 00261 00 122
5 00000 0 000
1 00261 33 000
2 00261 00 000
5 00000 1 000
2 00261 00 122
4 A4000 0 222
4 C4000 1 222
4 D4000 2 222
4 D7FFF 3 222
4 A0000 0 000
4 C4000 0 000
2 00378 00 1FF
1 00378 5A 000
2 0037A 00 15A
1 0037F C3 000
2 00378 00 1C3
2 00300 00 000
2 00380 00 000
6 00000 10 000
7 00000 3 000
F 00000 00 000
